// File: design/gmac_arp_cache.sv
`timescale 1ns/1ps

module gmac_arp_cache (
    input  logic                aximm_clk,
    input  logic                gmac_reg_count_reset_we,
    input  gmac_pkg::arp_cmd_t  arp_cmd,
    output gmac_pkg::reg_word_t arp_rdata
);

    // Entry n: low 32 bits at word 2n, high 16 bits at word 2n+1
    gmac_pkg::reg_word_t mem [gmac_pkg::ARP_DEPTH];

    always_ff @(posedge aximm_clk) begin
        if (arp_cmd.wr) begin
            mem[arp_cmd.addr] <= arp_cmd.wdata;
        end
    end

    // Read result held until the next read command
    always_ff @(posedge aximm_clk) begin
        if (gmac_reg_count_reset_we) begin
            arp_rdata <= '0;
        end else if (arp_cmd.rd) begin
            arp_rdata <= mem[arp_cmd.addr];
        end
    end

endmodule

// File: design/gmac_ctrl_top.sv
`timescale 1ns/1ps

module gmac_ctrl_top (
    input  logic                  aximm_clk,
    input  logic                  gmac_reg_count_reset_we,
    // APB slave
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  gmac_pkg::apb_addr_t   paddr,
    input  gmac_pkg::reg_word_t   pwdata,
    output gmac_pkg::reg_word_t   prdata,
    output logic                  pready,
    output logic                  pslverr,
    // Fabric stream flags
    input  gmac_pkg::gmac_beat_t  tx_beat,
    input  logic                  tx_ready,
    input  gmac_pkg::gmac_beat_t  rx_beat,
    input  logic                  rx_overrun,
    output gmac_pkg::gmac_cfg_t   cfg
);

    gmac_pkg::arp_cmd_t    arp_cmd;
    gmac_pkg::reg_word_t   arp_rdata;
    gmac_pkg::gmac_stats_t stats;
    logic                  count_clear;

    gmac_reg_bank u_reg_bank (
        .aximm_clk               (aximm_clk),
        .gmac_reg_count_reset_we (gmac_reg_count_reset_we),
        .psel                    (psel),
        .penable                 (penable),
        .pwrite                  (pwrite),
        .paddr                   (paddr),
        .pwdata                  (pwdata),
        .arp_rdata               (arp_rdata),
        .stats                   (stats),
        .prdata                  (prdata),
        .pready                  (pready),
        .pslverr                 (pslverr),
        .cfg                     (cfg),
        .arp_cmd                 (arp_cmd),
        .count_clear             (count_clear)
    );

    gmac_stat_counters u_stat_counters (
        .aximm_clk               (aximm_clk),
        .gmac_reg_count_reset_we (gmac_reg_count_reset_we),
        .count_clear             (count_clear),
        .tx_beat                 (tx_beat),
        .tx_ready                (tx_ready),
        .rx_beat                 (rx_beat),
        .rx_overrun              (rx_overrun),
        .stats                   (stats)
    );

    gmac_arp_cache u_arp_cache (
        .aximm_clk               (aximm_clk),
        .gmac_reg_count_reset_we (gmac_reg_count_reset_we),
        .arp_cmd                 (arp_cmd),
        .arp_rdata               (arp_rdata)
    );

endmodule

// File: design/gmac_pkg.sv
package gmac_pkg;

    // Bus and memory widths
    localparam int APB_ADDR_W = 8;
    localparam int REG_W      = 32;
    localparam int ARP_ADDR_W = 9;
    localparam int ARP_DEPTH  = 512;

    typedef logic [APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [REG_W-1:0]      reg_word_t;
    typedef logic [ARP_ADDR_W-1:0] arp_addr_t;

    // Configuration registers
    localparam apb_addr_t REG_MAC_H       = 8'h00;
    localparam apb_addr_t REG_MAC_L       = 8'h04;
    localparam apb_addr_t REG_LOCAL_IP    = 8'h08;
    localparam apb_addr_t REG_NETMASK     = 8'h0C;
    localparam apb_addr_t REG_GATEWAY     = 8'h10;
    localparam apb_addr_t REG_MCAST_IP    = 8'h14;
    localparam apb_addr_t REG_MCAST_MASK  = 8'h18;
    localparam apb_addr_t REG_UDP_PORT    = 8'h1C;
    localparam apb_addr_t REG_CORE_CTRL   = 8'h20;
    localparam apb_addr_t REG_COUNT_RESET = 8'h24;

    // ARP cache access
    localparam apb_addr_t REG_ARP_WR_EN   = 8'h28;
    localparam apb_addr_t REG_ARP_RD_EN   = 8'h2C;
    localparam apb_addr_t REG_ARP_WDATA   = 8'h30;
    localparam apb_addr_t REG_ARP_WADDR   = 8'h34;
    localparam apb_addr_t REG_ARP_RADDR   = 8'h38;
    localparam apb_addr_t REG_ARP_RDATA   = 8'h3C;

    // Identity and statistics, read only
    localparam apb_addr_t REG_CORE_TYPE   = 8'h40;
    localparam apb_addr_t REG_ARP_SIZE    = 8'h44;
    localparam apb_addr_t REG_WORD_SIZE   = 8'h48;
    localparam apb_addr_t REG_TX_PKT      = 8'h50;
    localparam apb_addr_t REG_TX_VALID    = 8'h54;
    localparam apb_addr_t REG_TX_OVF      = 8'h58;
    localparam apb_addr_t REG_RX_PKT      = 8'h5C;
    localparam apb_addr_t REG_RX_VALID    = 8'h60;
    localparam apb_addr_t REG_RX_OVF      = 8'h64;
    localparam apb_addr_t REG_RX_BAD      = 8'h68;

    // Power-up configuration
    localparam logic [47:0] DEF_MAC       = 48'hffff_ffff_ffff;
    localparam reg_word_t   DEF_IP        = 32'hC0A805C8;
    localparam reg_word_t   DEF_NETMASK   = 32'hFFFFFF00;
    localparam reg_word_t   DEF_GATEWAY   = 32'h00000001;
    localparam logic [15:0] DEF_UDP_PORT  = 16'h2710;
    localparam reg_word_t   DEF_CORE_CTRL = 32'h00000000;

    localparam reg_word_t CORE_TYPE = 32'h00100100;
    // MAC entries, two words each
    localparam reg_word_t ARP_SIZE  = 32'd256;
    // Bytes per fabric beat
    localparam reg_word_t WORD_SIZE = 32'd64;

    typedef struct packed {
        logic [47:0] mac;
        reg_word_t   local_ip;
        reg_word_t   netmask;
        reg_word_t   gateway;
        reg_word_t   mcast_ip;
        reg_word_t   mcast_mask;
        logic [15:0] udp_port;
        logic        enable;
    } gmac_cfg_t;

    typedef struct packed {
        logic valid;
        logic eof;
        logic bad;
    } gmac_beat_t;

    typedef struct packed {
        logic      wr;
        logic      rd;
        arp_addr_t addr;
        reg_word_t wdata;
    } arp_cmd_t;

    typedef struct packed {
        reg_word_t tx_pkt;
        reg_word_t tx_valid;
        reg_word_t tx_ovf;
        reg_word_t rx_pkt;
        reg_word_t rx_valid;
        reg_word_t rx_ovf;
        reg_word_t rx_bad;
    } gmac_stats_t;

endpackage

// File: design/gmac_reg_bank.sv
`timescale 1ns/1ps

module gmac_reg_bank (
    input  logic                   aximm_clk,
    input  logic                   gmac_reg_count_reset_we,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  gmac_pkg::apb_addr_t    paddr,
    input  gmac_pkg::reg_word_t    pwdata,
    input  gmac_pkg::reg_word_t    arp_rdata,
    input  gmac_pkg::gmac_stats_t  stats,
    output gmac_pkg::reg_word_t    prdata,
    output logic                   pready,
    output logic                   pslverr,
    output gmac_pkg::gmac_cfg_t    cfg,
    output gmac_pkg::arp_cmd_t     arp_cmd,
    output logic                   count_clear
);

    logic                access;
    logic                wr_access;
    logic                mapped;
    logic [15:0]         mac_h;
    gmac_pkg::reg_word_t mac_l;
    gmac_pkg::reg_word_t local_ip;
    gmac_pkg::reg_word_t netmask;
    gmac_pkg::reg_word_t gateway;
    gmac_pkg::reg_word_t mcast_ip;
    gmac_pkg::reg_word_t mcast_mask;
    logic [15:0]         udp_port;
    gmac_pkg::reg_word_t core_ctrl;
    gmac_pkg::reg_word_t arp_wdata;
    gmac_pkg::arp_addr_t arp_waddr;
    gmac_pkg::arp_addr_t arp_raddr;
    logic                arp_wr;
    logic                arp_rd;

    // No wait states, every access cycle completes
    assign access    = psel & penable;
    assign wr_access = access & pwrite;
    assign pready    = access;
    assign pslverr   = access & ~mapped;

    always_ff @(posedge aximm_clk) begin
        if (gmac_reg_count_reset_we) begin
            mac_h       <= gmac_pkg::DEF_MAC[47:32];
            mac_l       <= gmac_pkg::DEF_MAC[31:0];
            local_ip    <= gmac_pkg::DEF_IP;
            netmask     <= gmac_pkg::DEF_NETMASK;
            gateway     <= gmac_pkg::DEF_GATEWAY;
            mcast_ip    <= '0;
            mcast_mask  <= '0;
            udp_port    <= gmac_pkg::DEF_UDP_PORT;
            core_ctrl   <= gmac_pkg::DEF_CORE_CTRL;
            arp_wdata   <= '0;
            arp_waddr   <= '0;
            arp_raddr   <= '0;
            arp_wr      <= 1'b0;
            arp_rd      <= 1'b0;
            count_clear <= 1'b0;
        end else begin
            // Command strobes last one cycle
            arp_wr      <= 1'b0;
            arp_rd      <= 1'b0;
            count_clear <= 1'b0;
            if (wr_access) begin
                case (paddr)
                    gmac_pkg::REG_MAC_H:       mac_h       <= pwdata[15:0];
                    gmac_pkg::REG_MAC_L:       mac_l       <= pwdata;
                    gmac_pkg::REG_LOCAL_IP:    local_ip    <= pwdata;
                    gmac_pkg::REG_NETMASK:     netmask     <= pwdata;
                    gmac_pkg::REG_GATEWAY:     gateway     <= pwdata;
                    gmac_pkg::REG_MCAST_IP:    mcast_ip    <= pwdata;
                    gmac_pkg::REG_MCAST_MASK:  mcast_mask  <= pwdata;
                    gmac_pkg::REG_UDP_PORT:    udp_port    <= pwdata[15:0];
                    gmac_pkg::REG_CORE_CTRL:   core_ctrl   <= pwdata;
                    gmac_pkg::REG_COUNT_RESET: count_clear <= pwdata[0];
                    gmac_pkg::REG_ARP_WR_EN:   arp_wr      <= pwdata[0];
                    gmac_pkg::REG_ARP_RD_EN:   arp_rd      <= pwdata[0];
                    gmac_pkg::REG_ARP_WDATA:   arp_wdata   <= pwdata;
                    gmac_pkg::REG_ARP_WADDR:   arp_waddr   <= pwdata[8:0];
                    gmac_pkg::REG_ARP_RADDR:   arp_raddr   <= pwdata[8:0];
                    default: ;
                endcase
            end
        end
    end

    // Cache command built from the held address and data
    always_comb begin
        arp_cmd.wr    = arp_wr;
        arp_cmd.rd    = arp_rd;
        arp_cmd.addr  = arp_wr ? arp_waddr : arp_raddr;
        arp_cmd.wdata = arp_wdata;
    end

    always_comb begin
        cfg.mac        = {mac_h, mac_l};
        cfg.local_ip   = local_ip;
        cfg.netmask    = netmask;
        cfg.gateway    = gateway;
        cfg.mcast_ip   = mcast_ip;
        cfg.mcast_mask = mcast_mask;
        cfg.udp_port   = udp_port;
        cfg.enable     = core_ctrl[0];
    end

    // Read mux, also flags unmapped addresses
    always_comb begin
        prdata = '0;
        mapped = 1'b1;
        case (paddr)
            gmac_pkg::REG_MAC_H:      prdata = gmac_pkg::reg_word_t'(mac_h);
            gmac_pkg::REG_MAC_L:      prdata = mac_l;
            gmac_pkg::REG_LOCAL_IP:   prdata = local_ip;
            gmac_pkg::REG_NETMASK:    prdata = netmask;
            gmac_pkg::REG_GATEWAY:    prdata = gateway;
            gmac_pkg::REG_MCAST_IP:   prdata = mcast_ip;
            gmac_pkg::REG_MCAST_MASK: prdata = mcast_mask;
            gmac_pkg::REG_UDP_PORT:   prdata = gmac_pkg::reg_word_t'(udp_port);
            gmac_pkg::REG_CORE_CTRL:  prdata = core_ctrl;
            // Strobe registers always read back zero
            gmac_pkg::REG_COUNT_RESET,
            gmac_pkg::REG_ARP_WR_EN,
            gmac_pkg::REG_ARP_RD_EN:  prdata = '0;
            gmac_pkg::REG_ARP_WDATA:  prdata = arp_wdata;
            gmac_pkg::REG_ARP_WADDR:  prdata = gmac_pkg::reg_word_t'(arp_waddr);
            gmac_pkg::REG_ARP_RADDR:  prdata = gmac_pkg::reg_word_t'(arp_raddr);
            gmac_pkg::REG_ARP_RDATA:  prdata = arp_rdata;
            gmac_pkg::REG_CORE_TYPE:  prdata = gmac_pkg::CORE_TYPE;
            gmac_pkg::REG_ARP_SIZE:   prdata = gmac_pkg::ARP_SIZE;
            gmac_pkg::REG_WORD_SIZE:  prdata = gmac_pkg::WORD_SIZE;
            gmac_pkg::REG_TX_PKT:     prdata = stats.tx_pkt;
            gmac_pkg::REG_TX_VALID:   prdata = stats.tx_valid;
            gmac_pkg::REG_TX_OVF:     prdata = stats.tx_ovf;
            gmac_pkg::REG_RX_PKT:     prdata = stats.rx_pkt;
            gmac_pkg::REG_RX_VALID:   prdata = stats.rx_valid;
            gmac_pkg::REG_RX_OVF:     prdata = stats.rx_ovf;
            gmac_pkg::REG_RX_BAD:     prdata = stats.rx_bad;
            default:                  mapped = 1'b0;
        endcase
    end

endmodule

// File: design/gmac_stat_counters.sv
`timescale 1ns/1ps

module gmac_stat_counters (
    input  logic                  aximm_clk,
    input  logic                  gmac_reg_count_reset_we,
    input  logic                  count_clear,
    input  gmac_pkg::gmac_beat_t  tx_beat,
    input  logic                  tx_ready,
    input  gmac_pkg::gmac_beat_t  rx_beat,
    input  logic                  rx_overrun,
    output gmac_pkg::gmac_stats_t stats
);

    logic ev_tx_valid;
    logic ev_tx_pkt;
    logic ev_tx_ovf;
    logic ev_rx_valid;
    logic ev_rx_pkt;
    logic ev_rx_bad;
    logic ev_rx_ovf;

    function automatic gmac_pkg::reg_word_t bump(input gmac_pkg::reg_word_t cnt,
                                                 input logic ev);
        return cnt + gmac_pkg::reg_word_t'(ev);
    endfunction

    // Event decode from the beat flags
    always_comb begin
        ev_tx_valid = tx_beat.valid;
        ev_tx_pkt   = tx_beat.valid & tx_beat.eof;
        // Ready is only watched here, a beat without it is an overflow
        ev_tx_ovf   = tx_beat.valid & ~tx_ready;
        ev_rx_valid = rx_beat.valid;
        ev_rx_pkt   = rx_beat.valid & rx_beat.eof;
        ev_rx_bad   = rx_beat.valid & rx_beat.eof & rx_beat.bad;
        ev_rx_ovf   = rx_overrun;
    end

    always_ff @(posedge aximm_clk) begin
        if (gmac_reg_count_reset_we) begin
            stats <= '0;
        end else if (count_clear) begin
            // Events coinciding with the clear are lost
            stats <= '0;
        end else begin
            stats.tx_valid <= bump(stats.tx_valid, ev_tx_valid);
            stats.tx_pkt   <= bump(stats.tx_pkt, ev_tx_pkt);
            stats.tx_ovf   <= bump(stats.tx_ovf, ev_tx_ovf);
            stats.rx_valid <= bump(stats.rx_valid, ev_rx_valid);
            stats.rx_pkt   <= bump(stats.rx_pkt, ev_rx_pkt);
            stats.rx_bad   <= bump(stats.rx_bad, ev_rx_bad);
            stats.rx_ovf   <= bump(stats.rx_ovf, ev_rx_ovf);
        end
    end

endmodule

// File: gmac_ctrl.f
design/gmac_pkg.sv
design/gmac_arp_cache.sv
design/gmac_stat_counters.sv
design/gmac_reg_bank.sv
design/gmac_ctrl_top.sv
testbench/gmac_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator and run, pass only if the pass message shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps -f gmac_ctrl.f \
    --top-module gmac_ctrl_tb -o gmac_ctrl_sim \
    && ./obj_dir/gmac_ctrl_sim | tee /dev/stderr | grep -q "TESTBENCH PASSED" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: testbench/gmac_ctrl_tb.sv
`timescale 1ns/1ps

module gmac_ctrl_tb;

    typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_TX, OP_RX} op_t;

    // One table row with the cfg expected once the row is done
    typedef struct packed {
        op_t                 op;
        gmac_pkg::apb_addr_t addr;
        gmac_pkg::reg_word_t data;
        gmac_pkg::reg_word_t exp;
        logic                err;
        logic [7:0]          beats;
        logic [7:0]          k;
        logic                bad;
        gmac_pkg::gmac_cfg_t cfg;
    } row_t;

    localparam gmac_pkg::apb_addr_t CFG_ADDR [9] = '{
        gmac_pkg::REG_MAC_H, gmac_pkg::REG_MAC_L, gmac_pkg::REG_LOCAL_IP,
        gmac_pkg::REG_NETMASK, gmac_pkg::REG_GATEWAY, gmac_pkg::REG_MCAST_IP,
        gmac_pkg::REG_MCAST_MASK, gmac_pkg::REG_UDP_PORT, gmac_pkg::REG_CORE_CTRL};
    localparam gmac_pkg::reg_word_t CFG_DEF [9] = '{
        32'h0000_ffff, 32'hffff_ffff, 32'hc0a8_05c8, 32'hffff_ff00, 32'h0000_0001,
        32'h0, 32'h0, 32'h0000_2710, 32'h0};
    localparam gmac_pkg::reg_word_t CFG_NEW [9] = '{
        32'h1234_5a5b, 32'h6789_abcd, 32'h0a00_0002, 32'hffff_0000, 32'h0a00_0001,
        32'he000_0001, 32'hffff_ff00, 32'h0001_c350, 32'h0000_0001};

    logic                  aximm_clk;
    logic                  gmac_reg_count_reset_we;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    gmac_pkg::apb_addr_t   paddr;
    gmac_pkg::reg_word_t   pwdata;
    gmac_pkg::reg_word_t   prdata;
    logic                  pready;
    logic                  pslverr;
    gmac_pkg::gmac_beat_t  tx_beat;
    logic                  tx_ready;
    gmac_pkg::gmac_beat_t  rx_beat;
    logic                  rx_overrun;
    gmac_pkg::gmac_cfg_t   cfg;
    row_t                  rows[$];
    gmac_pkg::gmac_cfg_t   m_cfg;
    gmac_pkg::gmac_stats_t m_st;
    integer                seed;
    int                    pass_cnt;
    int                    fail_cnt;
    logic                  ok;
    logic                  table_ready = 1'b0;

    gmac_ctrl_top uut (
        .aximm_clk               (aximm_clk),
        .gmac_reg_count_reset_we (gmac_reg_count_reset_we),
        .psel                    (psel),
        .penable                 (penable),
        .pwrite                  (pwrite),
        .paddr                   (paddr),
        .pwdata                  (pwdata),
        .prdata                  (prdata),
        .pready                  (pready),
        .pslverr                 (pslverr),
        .tx_beat                 (tx_beat),
        .tx_ready                (tx_ready),
        .rx_beat                 (rx_beat),
        .rx_overrun              (rx_overrun),
        .cfg                     (cfg)
    );

    initial begin
        aximm_clk = 1'b0;
        forever #2 aximm_clk = ~aximm_clk;
    end

    task automatic add_row(input op_t op, input gmac_pkg::apb_addr_t addr,
                           input gmac_pkg::reg_word_t data, input gmac_pkg::reg_word_t exp,
                           input logic err, input int beats, input int k, input logic bad);
        row_t r;
        r = '{op, addr, data, exp, err, beats[7:0], k[7:0], bad, m_cfg};
        rows.push_back(r);
    endtask

    task automatic add_read(input gmac_pkg::apb_addr_t addr, input gmac_pkg::reg_word_t exp);
        add_row(OP_READ, addr, 32'h0, exp, 1'b0, 0, 0, 1'b0);
    endtask

    // Model of what a write does to cfg and the counters
    task automatic add_write(input gmac_pkg::apb_addr_t addr, input gmac_pkg::reg_word_t d);
        case (addr)
            gmac_pkg::REG_MAC_H:      m_cfg.mac[47:32] = d[15:0];
            gmac_pkg::REG_MAC_L:      m_cfg.mac[31:0]  = d;
            gmac_pkg::REG_LOCAL_IP:   m_cfg.local_ip   = d;
            gmac_pkg::REG_NETMASK:    m_cfg.netmask    = d;
            gmac_pkg::REG_GATEWAY:    m_cfg.gateway    = d;
            gmac_pkg::REG_MCAST_IP:   m_cfg.mcast_ip   = d;
            gmac_pkg::REG_MCAST_MASK: m_cfg.mcast_mask = d;
            gmac_pkg::REG_UDP_PORT:   m_cfg.udp_port   = d[15:0];
            gmac_pkg::REG_CORE_CTRL:  m_cfg.enable     = d[0];
            gmac_pkg::REG_COUNT_RESET: begin
                if (d[0]) m_st = '0;
            end
            default: ;
        endcase
        add_row(OP_WRITE, addr, d, 32'h0, 1'b0, 0, 0, 1'b0);
    endtask

    task automatic add_counts();
        add_read(gmac_pkg::REG_TX_PKT, m_st.tx_pkt);
        add_read(gmac_pkg::REG_TX_VALID, m_st.tx_valid);
        add_read(gmac_pkg::REG_TX_OVF, m_st.tx_ovf);
        add_read(gmac_pkg::REG_RX_PKT, m_st.rx_pkt);
        add_read(gmac_pkg::REG_RX_VALID, m_st.rx_valid);
        add_read(gmac_pkg::REG_RX_OVF, m_st.rx_ovf);
        add_read(gmac_pkg::REG_RX_BAD, m_st.rx_bad);
    endtask

    task automatic add_tx(input int n, input int k);
        m_st.tx_valid += n;
        m_st.tx_pkt   += 1;
        m_st.tx_ovf   += k;
        add_row(OP_TX, 8'h0, 32'h0, 32'h0, 1'b0, n, k, 1'b0);
    endtask

    task automatic add_rx(input int n, input int m, input logic bad);
        m_st.rx_valid += n;
        m_st.rx_pkt   += 1;
        m_st.rx_bad   += 32'(bad);
        m_st.rx_ovf   += m;
        add_row(OP_RX, 8'h0, 32'h0, 32'h0, 1'b0, n, m, bad);
    endtask

    task automatic build_table();
        gmac_pkg::arp_addr_t a [6];
        gmac_pkg::reg_word_t w [6];
        gmac_pkg::reg_word_t r;
        m_cfg = '{gmac_pkg::DEF_MAC, gmac_pkg::DEF_IP, gmac_pkg::DEF_NETMASK,
                  gmac_pkg::DEF_GATEWAY, 32'h0, 32'h0, gmac_pkg::DEF_UDP_PORT, 1'b0};
        m_st = '0;
        for (int i = 0; i < 9; i++) add_read(CFG_ADDR[i], CFG_DEF[i]);
        add_read(gmac_pkg::REG_CORE_TYPE, 32'h0010_0100);
        add_read(gmac_pkg::REG_ARP_SIZE, 32'd256);
        add_read(gmac_pkg::REG_WORD_SIZE, 32'd64);
        // ARP holding registers and the cache read register start at zero
        add_read(gmac_pkg::REG_ARP_WDATA, 32'h0);
        add_read(gmac_pkg::REG_ARP_WADDR, 32'h0);
        add_read(gmac_pkg::REG_ARP_RADDR, 32'h0);
        add_read(gmac_pkg::REG_ARP_RDATA, 32'h0);
        add_counts();
        // MAC high and UDP port keep 16 bits
        for (int i = 0; i < 9; i++) add_write(CFG_ADDR[i], CFG_NEW[i]);
        for (int i = 0; i < 9; i++) begin
            r = CFG_NEW[i];
            if (i == 0 || i == 7) r = {16'h0, r[15:0]};
            add_read(CFG_ADDR[i], r);
        end
        add_row(OP_READ, 8'h4C, 32'h0, 32'h0, 1'b1, 0, 0, 1'b0);
        add_write(gmac_pkg::REG_CORE_TYPE, 32'hdead_beef);
        add_read(gmac_pkg::REG_CORE_TYPE, 32'h0010_0100);
        // Three MAC entries at random indexes with the low word at 2n
        seed = 32'hdc8b;
        for (int i = 0; i < 3; i++) begin
            r = $random(seed);
            a[2*i]   = {r[5:0], i[1:0], 1'b0};
            a[2*i+1] = {r[5:0], i[1:0], 1'b1};
            w[2*i]   = $random(seed);
            r = $random(seed);
            w[2*i+1] = {16'h0, r[15:0]};
        end
        for (int j = 0; j < 6; j++) begin
            add_write(gmac_pkg::REG_ARP_WADDR, {23'h0, a[j]});
            add_write(gmac_pkg::REG_ARP_WDATA, w[j]);
            add_write(gmac_pkg::REG_ARP_WR_EN, 32'h1);
        end
        for (int j = 5; j >= 0; j--) begin
            add_write(gmac_pkg::REG_ARP_RADDR, {23'h0, a[j]});
            add_write(gmac_pkg::REG_ARP_RD_EN, 32'h1);
            add_read(gmac_pkg::REG_ARP_RDATA, w[j]);
        end
        add_read(gmac_pkg::REG_ARP_WR_EN, 32'h0);
        add_read(gmac_pkg::REG_ARP_RD_EN, 32'h0);
        add_tx(5, 2);
        add_counts();
        add_tx(3, 0);
        add_rx(4, 3, 1'b1);
        add_rx(2, 0, 1'b0);
        add_counts();
        add_write(gmac_pkg::REG_COUNT_RESET, 32'h1);
        add_counts();
        add_read(gmac_pkg::REG_LOCAL_IP, 32'h0a00_0002);
    endtask

    task automatic apb_xfer(input logic wr, input gmac_pkg::apb_addr_t addr,
                            input gmac_pkg::reg_word_t data, output gmac_pkg::reg_word_t rd,
                            output logic err, output logic rdy);
        @(negedge aximm_clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = data;
        @(negedge aximm_clk);
        penable = 1'b1;
        // Sample mid access cycle ahead of the edge
        #1;
        rd  = prdata;
        err = pslverr;
        rdy = pready;
        @(negedge aximm_clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic run_row(input row_t r, output logic pass);
        gmac_pkg::reg_word_t rd;
        logic                err;
        logic                rdy;
        pass = 1'b1;
        if (r.op == OP_WRITE || r.op == OP_READ) begin
            apb_xfer(r.op == OP_WRITE, r.addr, r.data, rd, err, rdy);
            if (rdy !== 1'b1 || err !== r.err) begin
                $display("FAIL %0t: addr 0x%02h pready %b pslverr %b, expected pslverr %b",
                         $time, r.addr, rdy, err, r.err);
                pass = 1'b0;
            end
            if (r.op == OP_READ && !r.err && rd !== r.exp) begin
                $display("FAIL %0t: addr 0x%02h read 0x%08h, expected 0x%08h",
                         $time, r.addr, rd, r.exp);
                pass = 1'b0;
            end
        end else begin
            // Burst with eof on the last beat
            // k counts ready-low beats or overrun cycles
            for (int i = 0; i < r.beats; i++) begin
                @(negedge aximm_clk);
                if (r.op == OP_TX) begin
                    tx_beat  = '{1'b1, i == r.beats - 1, 1'b0};
                    tx_ready = (i >= r.k);
                end else begin
                    rx_beat    = '{1'b1, i == r.beats - 1, (i == r.beats - 1) & r.bad};
                    rx_overrun = (i < r.k);
                end
            end
            @(negedge aximm_clk);
            tx_beat    = '0;
            tx_ready   = 1'b1;
            rx_beat    = '0;
            rx_overrun = 1'b0;
        end
        if (cfg !== r.cfg) begin
            $display("FAIL %0t: cfg output 0x%h, expected 0x%h", $time, cfg, r.cfg);
            pass = 1'b0;
        end
    endtask

    initial begin
        gmac_reg_count_reset_we = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        tx_beat    = '0;
        tx_ready   = 1'b1;
        rx_beat    = '0;
        rx_overrun = 1'b0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(posedge aximm_clk);
        @(negedge aximm_clk);
        gmac_reg_count_reset_we = 1'b0;
        if (pready !== 1'b0 || pslverr !== 1'b0) begin
            $display("FAIL %0t: pready or pslverr high after reset", $time);
            fail_cnt++;
        end
        foreach (rows[i]) begin
            run_row(rows[i], ok);
            if (ok) begin
                pass_cnt++;
                $display("row %0d op %0d addr 0x%02h ok", i, rows[i].op, rows[i].addr);
            end else begin
                fail_cnt++;
                $display("row %0d op %0d addr 0x%02h had errors", i, rows[i].op, rows[i].addr);
            end
        end
        $display("Rows passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        wait (table_ready === 1'b1);
        repeat (rows.size() * 20 + 100) @(posedge aximm_clk);
        $display("Run timed out before the table completed");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
